//--- files.f
+incdir+test
verilog/lb_pack.sv
verilog/lb_regs.sv
verilog/trace_capture.sv
verilog/status_leds.sv
verilog/lb_subsys_top.sv
test/tb_lb_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the local-bus subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_lb_subsys -f files.f -o tb_lb_subsys

# Simulator exit status is not used, the log decides
./obj_dir/tb_lb_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   echo "RESULT: FAIL"
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   echo "RESULT: FAIL, run ended without a result line"
   exit 1
fi
echo "RESULT: PASS"

//--- test/tb_lb_vectors.svh
// ------------------------------
// Stimulus table for the local-bus testbench
// Operation codes and row layout
// ------------------------------

// Columns: operation, address, data, compare mask, expected value
// Run rows use the address as run length and data as sample
// Capture rows use the address as the cycle of a second start, 0 for none
localparam logic [3:0] OP_WRITE   = 4'd0;
localparam logic [3:0] OP_READ    = 4'd1;
localparam logic [3:0] OP_READ2   = 4'd2;
localparam logic [3:0] OP_RUN     = 4'd3;
localparam logic [3:0] OP_CAPTURE = 4'd4;
localparam logic [3:0] OP_RANDCAP = 4'd5;
localparam logic [3:0] OP_TRACE   = 4'd6;
localparam logic [3:0] OP_LED     = 4'd7;

typedef struct packed {
   logic [3:0]  op;
   logic [23:0] addr;
   logic [31:0] data;
   logic [31:0] mask;
   logic [31:0] exp;
} vec_t;

// Status after a full capture: done, not busy, count at depth
localparam logic [31:0] STAT_FULL = (32'(DEPTH) << STAT_COUNT_LSB) | (32'd1 << STAT_DONE_BIT);
// Override on with LED value 4'ha
localparam logic [31:0] CTRL_OVR_A = (32'd1 << CTRL_LED_OVR_BIT) | (32'ha << CTRL_LED_LSB);

localparam int NUM_VECS = 27;
localparam vec_t VECTORS [NUM_VECS] = '{
   // ID, scratch, unmapped and back-to-back reads
   {OP_READ,    24'(ADDR_ID),      32'h0,         32'hffff_ffff, LB_ID_VALUE},
   {OP_WRITE,   24'(ADDR_SCRATCH), 32'h5a5a_c3c3, 32'h0,         32'h0},
   {OP_READ,    24'(ADDR_SCRATCH), 32'h0,         32'hffff_ffff, 32'h5a5a_c3c3},
   {OP_READ,    24'h00_0004,       32'h0,         32'hffff_ffff, LB_BAD_ADDR_VALUE},
   {OP_READ,    24'h40_1000,       32'h0,         32'hffff_ffff, LB_BAD_ADDR_VALUE},
   {OP_READ2,   24'(ADDR_SCRATCH), 32'h0,         32'hffff_ffff, 32'h5a5a_c3c3},
   // Known runs, then capture to full
   {OP_RUN,     24'd5,             32'h0000_00a1, 32'h0,         32'h0},
   {OP_RUN,     24'd1,             32'h0000_0003, 32'h0,         32'h0},
   {OP_RUN,     24'd9,             32'h0000_beef, 32'h0,         32'h0},
   {OP_CAPTURE, 24'd0,             32'h0,         32'h0,         32'h0},
   {OP_READ,    24'(ADDR_STATUS),  32'h0,         32'hffff_ffff, STAT_FULL},
   {OP_TRACE,   24'd0,             32'h0,         32'h0,         32'h0},
   // Same runs with a start while busy
   {OP_RUN,     24'd5,             32'h0000_00a1, 32'h0,         32'h0},
   {OP_RUN,     24'd1,             32'h0000_0003, 32'h0,         32'h0},
   {OP_RUN,     24'd9,             32'h0000_beef, 32'h0,         32'h0},
   {OP_CAPTURE, 24'd6,             32'h0,         32'h0,         32'h0},
   {OP_READ,    24'(ADDR_STATUS),  32'h0,         32'hffff_ffff, STAT_FULL},
   {OP_TRACE,   24'd0,             32'h0,         32'h0,         32'h0},
   // Random samples, every run one long
   {OP_RANDCAP, 24'd0,             32'h0,         32'h0,         32'h0},
   {OP_READ,    24'(ADDR_STATUS),  32'h0,         32'hffff_ffff, STAT_FULL},
   {OP_TRACE,   24'd0,             32'h0,         32'h0,         32'h0},
   // LED override, then lock and done bits
   {OP_WRITE,   24'(ADDR_CONTROL), CTRL_OVR_A,    32'h0,         32'h0},
   {OP_READ,    24'(ADDR_CONTROL), 32'h0,         32'hffff_ffff, CTRL_OVR_A},
   {OP_LED,     24'd0,             32'h0,         32'h0000_000f, 32'h0000_000a},
   {OP_WRITE,   24'(ADDR_CONTROL), 32'h0,         32'h0,         32'h0},
   {OP_LED,     24'd0,             32'h1,         32'h0000_0009, 32'h0000_0009},
   {OP_LED,     24'd0,             32'h0,         32'h0000_0009, 32'h0000_0001}
};

//--- test/tb_lb_subsys.sv
// ------------------------------
// Testbench for the local-bus subsystem
// Clock, reset, bus tasks, run-length model
// Loop over the stimulus table
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_lb_subsys;
   import lb_pack::*;

   localparam int TRACE_AW = 6;
   localparam int HB_BIT   = 4;
   localparam int DEPTH    = 2**TRACE_AW;

   logic        lb_clk = 1'b0;
   logic        i_rst_n;
   logic        i_lb_valid;
   logic        i_lb_rnw;
   logic        i_lb_renable;
   logic [23:0] i_lb_addr;
   logic [31:0] i_lb_wdata;
   logic [31:0] o_lb_rdata;
   logic [15:0] i_probe;
   logic        i_gt_locked;
   logic [3:0]  o_led;

   integer      seed = 32'h7b5d8a96;
   // Samples still to drive, samples driven, entries expected
   logic [15:0] sched_q [$];
   logic [15:0] driven_q [$];
   logic [31:0] expect_q [$];

   `include "tb_lb_vectors.svh"

   lb_subsys_top #(
      .TRACE_AW (TRACE_AW),
      .HB_BIT   (HB_BIT))
   i_lb_subsys_top (
      .lb_clk       (lb_clk),
      .i_rst_n      (i_rst_n),
      .i_lb_valid   (i_lb_valid),
      .i_lb_rnw     (i_lb_rnw),
      .i_lb_renable (i_lb_renable),
      .i_lb_addr    (i_lb_addr),
      .i_lb_wdata   (i_lb_wdata),
      .o_lb_rdata   (o_lb_rdata),
      .i_probe      (i_probe),
      .i_gt_locked  (i_gt_locked),
      .o_led        (o_led)
   );

   // 100 ns clock
   always #50 lb_clk = ~lb_clk;

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s: got %h, expected %h", name, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // ------------------------------
   // Bus tasks, called on a falling edge
   // ------------------------------
   task automatic bus_write(input logic [23:0] addr, input logic [31:0] data);
      i_lb_valid = 1'b1;
      i_lb_rnw   = 1'b0;
      i_lb_addr  = addr;
      i_lb_wdata = data;
      @(negedge lb_clk);
      i_lb_valid = 1'b0;
   endtask

   // Data is two cycles behind the strobe
   task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
      i_lb_valid   = 1'b1;
      i_lb_rnw     = 1'b1;
      i_lb_renable = 1'b1;
      i_lb_addr    = addr;
      @(negedge lb_clk);
      i_lb_valid   = 1'b0;
      i_lb_renable = 1'b0;
      @(negedge lb_clk);
      data = o_lb_rdata;
   endtask

   // Two strobes in a row, results on consecutive cycles
   task automatic bus_read_pair(input logic [23:0] addr_a, input logic [23:0] addr_b,
                                output logic [31:0] data_a, output logic [31:0] data_b);
      i_lb_valid   = 1'b1;
      i_lb_rnw     = 1'b1;
      i_lb_renable = 1'b1;
      i_lb_addr    = addr_a;
      @(negedge lb_clk);
      i_lb_addr    = addr_b;
      @(negedge lb_clk);
      i_lb_valid   = 1'b0;
      i_lb_renable = 1'b0;
      data_a = o_lb_rdata;
      @(negedge lb_clk);
      data_b = o_lb_rdata;
   endtask

   // ------------------------------
   // Run-length model of the driven stream
   // ------------------------------
   task automatic build_model();
      logic [15:0] held;
      logic [15:0] run;
      expect_q.delete();
      held = driven_q[0];
      run  = 16'd1;
      for (int i = 1; i < driven_q.size() && expect_q.size() < DEPTH; i++) begin
         // Entry closes on a new sample or a saturated counter
         if (driven_q[i] != held || run == 16'hffff) begin
            expect_q.push_back({run, held});
            held = driven_q[i];
            run  = 16'd1;
         end else begin
            run = run + 16'd1;
         end
      end
      if (expect_q.size() != DEPTH) begin
         $display("Capture ended before the driven samples filled the trace memory");
         $display("Simulation failed");
         $fatal(1, "short capture");
      end
   endtask

   // Start, then one sample per clock until the done LED rises
   task automatic run_capture(input int restart_at, input bit use_random);
      logic [15:0] smp;
      int          cyc;
      driven_q.delete();
      bus_write(24'(ADDR_CONTROL), 32'd1 << CTRL_START_BIT);
      for (cyc = 0; cyc < 4 * DEPTH; cyc++) begin
         @(negedge lb_clk);
         i_lb_valid = 1'b0;
         if (o_led[0])
            break;
         if (use_random) begin
            smp = 16'($random(seed));
            while (driven_q.size() > 0 && smp == driven_q[$])
               smp = 16'($random(seed));
         end else if (sched_q.size() > 0) begin
            smp = sched_q.pop_front();
         end else begin
            // Filler, a new value every cycle
            smp = driven_q[$] + 16'd1;
         end
         i_probe = smp;
         driven_q.push_back(smp);
         // Second start while busy
         if (restart_at > 0 && cyc == restart_at) begin
            i_lb_valid = 1'b1;
            i_lb_rnw   = 1'b0;
            i_lb_addr  = 24'(ADDR_CONTROL);
            i_lb_wdata = 32'd1 << CTRL_START_BIT;
         end
      end
      if (!o_led[0]) begin
         $display("Timeout while waiting for the trace capture to finish");
         $display("Simulation failed");
         $fatal(1, "timeout");
      end
      build_model();
   endtask

   task automatic check_trace();
      logic [31:0] word;
      for (int i = 0; i < DEPTH; i++) begin
         bus_read((24'd1 << TRACE_SEL_BIT) | 24'(i), word);
         check_value($sformatf("o_lb_rdata trace[%0d]", i), word, expect_q[i]);
      end
   endtask

   // ------------------------------
   // Reset and table loop
   // ------------------------------
   initial begin
      vec_t        v;
      logic [31:0] word;
      logic [31:0] word_b;
      i_rst_n      = 1'b0;
      i_lb_valid   = 1'b0;
      i_lb_rnw     = 1'b0;
      i_lb_renable = 1'b0;
      i_lb_addr    = '0;
      i_lb_wdata   = '0;
      i_probe      = '0;
      i_gt_locked  = 1'b0;
      repeat (16) @(negedge lb_clk);
      i_rst_n = 1'b1;
      @(negedge lb_clk);
      check_value("o_lb_rdata", o_lb_rdata, 32'h0);
      for (int n = 0; n < NUM_VECS; n++) begin
         v = VECTORS[n];
         case (v.op)
            OP_WRITE: bus_write(v.addr, v.data);
            OP_READ: begin
               bus_read(v.addr, word);
               check_value("o_lb_rdata", word & v.mask, v.exp);
            end
            OP_READ2: begin
               bus_read_pair(v.addr, 24'(ADDR_ID), word, word_b);
               check_value("o_lb_rdata first", word & v.mask, v.exp);
               check_value("o_lb_rdata second", word_b, LB_ID_VALUE);
            end
            OP_RUN: repeat (int'(v.addr)) sched_q.push_back(v.data[15:0]);
            OP_CAPTURE: run_capture(int'(v.addr), 1'b0);
            OP_RANDCAP: run_capture(0, 1'b1);
            OP_TRACE: check_trace();
            OP_LED: begin
               i_gt_locked = v.data[0];
               @(negedge lb_clk);
               check_value("o_led", 32'(o_led) & v.mask, v.exp);
            end
            default: begin
               $display("Unknown operation in stimulus row %0d", n);
               $display("Simulation failed");
               $fatal(1, "bad row");
            end
         endcase
      end
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/lb_subsys_top.sv
// ----------------------------
// Local-bus subsystem top level
// Registers, trace capture, LEDs
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module lb_subsys_top
   import lb_pack::*;
#(
   parameter int TRACE_AW = 6,
   parameter int HB_BIT   = 4
) (
   input  logic                          lb_clk,
   input  logic                          i_rst_n,
   // Local bus from the Ethernet bridge
   input  logic                          i_lb_valid,
   input  logic                          i_lb_rnw,
   input  logic                          i_lb_renable,
   input  logic [LBUS_ADDR_WIDTH-1:0]    i_lb_addr,
   input  logic [LBUS_DATA_WIDTH-1:0]    i_lb_wdata,
   output logic [LBUS_DATA_WIDTH-1:0]    o_lb_rdata,
   // Probe and board status
   input  logic [TRACE_SAMPLE_WIDTH-1:0] i_probe,
   input  logic                          i_gt_locked,
   output logic [3:0]                    o_led
);

   logic                trace_start;
   logic [TRACE_AW-1:0] trace_raddr;
   trace_word_u         trace_rword;
   logic                trace_busy;
   logic                trace_done;
   logic [TRACE_AW:0]   trace_count;
   logic                led_ovr;
   logic [3:0]          led_val;
   logic                rd_activity;

   // ----------------------------
   // Register block
   // ----------------------------
   lb_regs #(
      .TRACE_AW (TRACE_AW))
   i_lb_regs (
      .lb_clk        (lb_clk),
      .i_rst_n       (i_rst_n),
      .i_lb_valid    (i_lb_valid),
      .i_lb_rnw      (i_lb_rnw),
      .i_lb_renable  (i_lb_renable),
      .i_lb_addr     (i_lb_addr),
      .i_lb_wdata    (i_lb_wdata),
      .o_lb_rdata    (o_lb_rdata),
      .o_trace_start (trace_start),
      .o_trace_raddr (trace_raddr),
      .i_trace_rword (trace_rword),
      .i_trace_busy  (trace_busy),
      .i_trace_done  (trace_done),
      .i_trace_count (trace_count),
      .o_led_ovr     (led_ovr),
      .o_led_val     (led_val),
      .o_rd_activity (rd_activity)
   );

   // Capture runs in lb_clk, no crossing needed
   trace_capture #(
      .TRACE_AW (TRACE_AW))
   i_trace_capture (
      .lb_clk  (lb_clk),
      .i_rst_n (i_rst_n),
      .i_start (trace_start),
      .i_probe (i_probe),
      .o_busy  (trace_busy),
      .o_done  (trace_done),
      .o_count (trace_count),
      .i_raddr (trace_raddr),
      .o_rword (trace_rword)
   );

   status_leds #(
      .HB_BIT (HB_BIT))
   i_status_leds (
      .lb_clk        (lb_clk),
      .i_rst_n       (i_rst_n),
      .i_gt_locked   (i_gt_locked),
      .i_trace_done  (trace_done),
      .i_rd_activity (rd_activity),
      .i_led_ovr     (led_ovr),
      .i_led_val     (led_val),
      .o_led         (o_led)
   );

endmodule

`default_nettype wire

//--- verilog/status_leds.sv
// ----------------------------
// Heartbeat and activity stretcher
// LED select with override
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module status_leds #(
   parameter int HB_BIT = 4
) (
   input  logic       lb_clk,
   input  logic       i_rst_n,
   input  logic       i_gt_locked,
   input  logic       i_trace_done,
   input  logic       i_rd_activity,
   input  logic       i_led_ovr,
   input  logic [3:0] i_led_val,
   output logic [3:0] o_led
);

   logic [HB_BIT:0] hb_cnt;
   logic [3:0]      act_cnt;
   logic            act_on;

   // Free-running heartbeat, stretch each read to 8 cycles
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         hb_cnt  <= '0;
         act_cnt <= '0;
      end else begin
         hb_cnt <= hb_cnt + 1'b1;
         if (i_rd_activity)
            act_cnt <= 4'd8;
         else if (act_on)
            act_cnt <= act_cnt - 1'b1;
      end
   end

   assign act_on = (act_cnt != 4'd0);

   // Lock, heartbeat, activity, trace done
   assign o_led = i_led_ovr ? i_led_val
                            : {i_gt_locked, hb_cnt[HB_BIT], act_on, i_trace_done};

endmodule

`default_nettype wire

//--- verilog/trace_capture.sv
// ----------------------------
// Run-length trace capture engine
// Trace memory with registered read
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module trace_capture
   import lb_pack::*;
#(
   parameter int TRACE_AW = 6
) (
   input  logic                          lb_clk,
   input  logic                          i_rst_n,
   // Control from register block
   input  logic                          i_start,
   // Probe sample, one per clock
   input  logic [TRACE_SAMPLE_WIDTH-1:0] i_probe,
   // Status
   output logic                          o_busy,
   output logic                          o_done,
   output logic [TRACE_AW:0]             o_count,
   // Readback port
   input  logic [TRACE_AW-1:0]           i_raddr,
   output trace_word_u                   o_rword
);

   localparam int DEPTH = 2**TRACE_AW;

   logic [TRACE_SAMPLE_WIDTH-1:0] held;
   logic [TRACE_RUN_WIDTH-1:0]    run_cnt;
   logic                          primed;
   logic                          run_end;
   logic                          wr_en;
   logic                          last_entry;
   logic [TRACE_AW-1:0]           wr_addr;
   trace_word_u                   wr_word;
   trace_word_u                   mem [DEPTH];

   // ----------------------------
   // Run detection
   // ----------------------------
   // Run closes on a new value or a full counter
   assign run_end = (i_probe != held) || (run_cnt == '1);

   // No entry until a first sample is held
   assign wr_en = o_busy && primed && run_end;

   // Count doubles as the write pointer
   assign wr_addr    = o_count[TRACE_AW-1:0];
   assign last_entry = (wr_addr == '1);

   // Entry is run length over sample
   always_comb begin
      wr_word.entry.run_len = run_cnt;
      wr_word.entry.sample  = held;
   end

   // ----------------------------
   // Capture control
   // ----------------------------
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         o_busy  <= 1'b0;
         o_done  <= 1'b0;
         o_count <= '0;
         primed  <= 1'b0;
      end else if (i_start && !o_busy) begin
         // New capture, previous done cleared
         o_busy  <= 1'b1;
         o_done  <= 1'b0;
         o_count <= '0;
         primed  <= 1'b0;
      end else if (o_busy) begin
         primed <= 1'b1;
         if (wr_en) begin
            o_count <= o_count + 1'b1;
            // Memory full after this entry
            if (last_entry) begin
               o_busy <= 1'b0;
               o_done <= 1'b1;
            end
         end
      end
   end

   // Held sample and run length
   always_ff @(posedge lb_clk) begin
      if (o_busy) begin
         if (!primed || run_end) begin
            held    <= i_probe;
            run_cnt <= TRACE_RUN_WIDTH'(1);
         end else begin
            run_cnt <= run_cnt + 1'b1;
         end
      end
   end

   // ----------------------------
   // Trace memory
   // ----------------------------
   always_ff @(posedge lb_clk) begin
      if (wr_en)
         mem[wr_addr] <= wr_word;
      // Read is registered, one cycle after address
      o_rword <= mem[i_raddr];
   end

   // ----------------------------
   // Checks
   // ----------------------------
   // Pointer stays inside the memory for the whole capture
   a_addr_bound: assert property (@(posedge lb_clk) disable iff (!i_rst_n)
      o_busy |-> (o_count < (TRACE_AW+1)'(DEPTH)));

   // Busy hands over to done, never both
   a_busy_done: assert property (@(posedge lb_clk) disable iff (!i_rst_n)
      !(o_busy && o_done));

endmodule

`default_nettype wire

//--- verilog/lb_regs.sv
// ----------------------------
// Local-bus address decode
// Control, scratch and status registers
// Two-stage read-data pipeline
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module lb_regs
   import lb_pack::*;
#(
   parameter int TRACE_AW = 6
) (
   input  logic                       lb_clk,
   input  logic                       i_rst_n,
   // Local bus from the Ethernet bridge
   input  logic                       i_lb_valid,
   input  logic                       i_lb_rnw,
   input  logic                       i_lb_renable,
   input  logic [LBUS_ADDR_WIDTH-1:0] i_lb_addr,
   input  logic [LBUS_DATA_WIDTH-1:0] i_lb_wdata,
   output logic [LBUS_DATA_WIDTH-1:0] o_lb_rdata,
   // Trace capture engine
   output logic                       o_trace_start,
   output logic [TRACE_AW-1:0]        o_trace_raddr,
   input  trace_word_u                i_trace_rword,
   input  logic                       i_trace_busy,
   input  logic                       i_trace_done,
   input  logic [TRACE_AW:0]          i_trace_count,
   // LED driver
   output logic                       o_led_ovr,
   output logic [3:0]                 o_led_val,
   output logic                       o_rd_activity
);

   logic [TRACE_SEL_BIT-1:0]   reg_addr;
   logic                       reg_space;
   logic                       wr_en;
   logic                       rd_en;
   logic                       ctrl_sel;
   logic [LBUS_DATA_WIDTH-1:0] scratch;
   logic [LBUS_DATA_WIDTH-1:0] ctrl_word;
   logic [LBUS_DATA_WIDTH-1:0] status_word;
   logic [LBUS_DATA_WIDTH-1:0] reg_mux;
   logic [LBUS_DATA_WIDTH-1:0] reg_rdata_s1;
   logic                       rd_valid_s1;
   logic                       rd_trace_s1;

   // ----------------------------
   // Decode
   // ----------------------------
   assign reg_addr  = i_lb_addr[TRACE_SEL_BIT-1:0];
   assign reg_space = ~i_lb_addr[TRACE_SEL_BIT];
   assign wr_en     = i_lb_valid & ~i_lb_rnw;
   assign rd_en     = i_lb_valid & i_lb_rnw & i_lb_renable;
   assign ctrl_sel  = reg_space && (reg_addr == ADDR_CONTROL);

   // Memory address goes straight out, memory registers it
   assign o_trace_raddr = i_lb_addr[TRACE_AW-1:0];

   // ----------------------------
   // Write side
   // ----------------------------
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         o_trace_start <= 1'b0;
         o_led_ovr     <= 1'b0;
         o_led_val     <= '0;
         scratch       <= '0;
      end else begin
         // Start bit never stored, one pulse per write
         o_trace_start <= wr_en & ctrl_sel & i_lb_wdata[CTRL_START_BIT];
         if (wr_en && ctrl_sel) begin
            o_led_ovr <= i_lb_wdata[CTRL_LED_OVR_BIT];
            o_led_val <= i_lb_wdata[CTRL_LED_LSB +: 4];
         end
         if (wr_en && reg_space && (reg_addr == ADDR_SCRATCH))
            scratch <= i_lb_wdata;
      end
   end

   // Readback views
   always_comb begin
      ctrl_word = '0;
      ctrl_word[CTRL_LED_OVR_BIT] = o_led_ovr;
      ctrl_word[CTRL_LED_LSB +: 4] = o_led_val;
   end

   always_comb begin
      status_word = '0;
      status_word[STAT_BUSY_BIT] = i_trace_busy;
      status_word[STAT_DONE_BIT] = i_trace_done;
      status_word[STAT_COUNT_LSB +: TRACE_AW+1] = i_trace_count;
   end

   always_comb begin
      case (reg_addr)
         ADDR_ID:      reg_mux = LB_ID_VALUE;
         ADDR_CONTROL: reg_mux = ctrl_word;
         ADDR_STATUS:  reg_mux = status_word;
         ADDR_SCRATCH: reg_mux = scratch;
         default:      reg_mux = LB_BAD_ADDR_VALUE;
      endcase
   end

   // ----------------------------
   // Read pipeline
   // ----------------------------
   // Stage 1 lines up with the memory read register
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         rd_valid_s1 <= 1'b0;
      end else begin
         rd_valid_s1 <= rd_en;
      end
   end

   always_ff @(posedge lb_clk) begin
      reg_rdata_s1 <= reg_mux;
      rd_trace_s1  <= i_lb_addr[TRACE_SEL_BIT];
   end

   // Stage 2 output register, holds until the next read
   always_ff @(posedge lb_clk) begin
      if (!i_rst_n) begin
         o_lb_rdata <= '0;
      end else if (rd_valid_s1) begin
         o_lb_rdata <= rd_trace_s1 ? i_trace_rword.raw : reg_rdata_s1;
      end
   end

   // One pulse per read for the activity LED
   assign o_rd_activity = rd_valid_s1;

   // ----------------------------
   // Checks
   // ----------------------------
   // Start and override writes need a defined address
   a_ctrl_write: assert property (@(posedge lb_clk) disable iff (!i_rst_n)
      wr_en |-> !$isunknown(i_lb_addr));

   // Read data only updates two cycles after a read strobe
   a_rdata_latency: assert property (@(posedge lb_clk) disable iff (!i_rst_n)
      $changed(o_lb_rdata) |-> $past(rd_en, 2));

endmodule

`default_nettype wire

//--- verilog/lb_pack.sv
// ----------------------------
// Local-bus widths and register map
// Control and status bit positions
// Trace word with entry and raw views
// ----------------------------
`default_nettype none

package lb_pack;

   // Bus widths
   localparam int LBUS_ADDR_WIDTH = 24;
   localparam int LBUS_DATA_WIDTH = 32;

   // High address bit steers reads to the trace memory
   localparam int TRACE_SEL_BIT = 23;

   // Register word addresses in the lower address space
   localparam logic [TRACE_SEL_BIT-1:0] ADDR_ID      = 'd0;
   localparam logic [TRACE_SEL_BIT-1:0] ADDR_CONTROL = 'd1;
   localparam logic [TRACE_SEL_BIT-1:0] ADDR_STATUS  = 'd2;
   localparam logic [TRACE_SEL_BIT-1:0] ADDR_SCRATCH = 'd3;

   localparam logic [LBUS_DATA_WIDTH-1:0] LB_ID_VALUE       = 32'h6c62_0a01;
   localparam logic [LBUS_DATA_WIDTH-1:0] LB_BAD_ADDR_VALUE = 32'hbad0_add0;

   // Control word bits
   localparam int CTRL_START_BIT   = 0;
   localparam int CTRL_LED_OVR_BIT = 1;
   localparam int CTRL_LED_LSB     = 2;

   // Status word bits, count field is TRACE_AW+1 wide
   localparam int STAT_BUSY_BIT  = 0;
   localparam int STAT_DONE_BIT  = 1;
   localparam int STAT_COUNT_LSB = 16;

   // Trace entry fields
   localparam int TRACE_SAMPLE_WIDTH = 16;
   localparam int TRACE_RUN_WIDTH    = 16;

   // One memory word, built as an entry and read back raw
   typedef union packed {
      struct packed {
         logic [TRACE_RUN_WIDTH-1:0]    run_len;
         logic [TRACE_SAMPLE_WIDTH-1:0] sample;
      } entry;
      logic [LBUS_DATA_WIDTH-1:0] raw;
   } trace_word_u;

endpackage

`default_nettype wire
